// File: all.f
rtl/uart_pkg.sv
rtl/wb_pkg.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/uart_regs.sv
rtl/uart_top.sv
testbench/uart_props.sv
testbench/uart_tb.sv

// File: Makefile
# Verilator flow for the UART testbench. Override any variable on the command line.
VERILATOR ?= verilator
TOP       ?= uart_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
JOBS      ?= 4

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# The binary exits non-zero on $fatal or a failed assertion.
sim:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		-f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: testbench/uart_tb.sv
// Bit timing assumes the default parameters, 16 clocks per bit and one stop bit; stops at first error.
`timescale 1ns/1ps
`default_nettype none

module uart_tb;
    import wb_pkg::*;

    // Default build: 125 MHz clock and 7.8125 Mbit/s line.
    localparam int CYCLES_PER_BIT = (125_000_000 - 1) / 7_812_500;
    localparam int BIT_CYCLES     = CYCLES_PER_BIT + 1;
    localparam int BUS_TIMEOUT    = 16;
    localparam int WAIT_TIMEOUT   = 400;

    // Status bits from the register map.
    localparam logic [7:0] VALID_MASK = 8'h01;
    localparam logic [7:0] BUSY_MASK  = 8'h02;
    localparam logic [7:0] RTS_MASK   = 8'h04;

    logic    clk;
    logic    resetn;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;
    logic    rxd_line;
    logic    loopback;
    logic    uart_rxd;
    logic    uart_txd;
    logic    uart_rts;
    integer  seed;

    // Loopback feeds the transmitter straight into the receiver.
    assign uart_rxd = loopback ? uart_txd : rxd_line;

    uart_top uart_top_i (
        .clk      (clk),
        .resetn   (resetn),
        .wb_req   (wb_req),
        .wb_rsp   (wb_rsp),
        .uart_rxd (uart_rxd),
        .uart_txd (uart_txd),
        .uart_rts (uart_rts)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------------------------------------
    // Reporting
    // ------------------------------------------------------------

    task automatic stop_with_failure();
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_eq(input logic [7:0] got, input logic [7:0] expected,
                            input string what);
        if (got !== expected) begin
            $display("ERROR %0t ns: %s: got 0x%02h, expected 0x%02h",
                     $time, what, got, expected);
            stop_with_failure();
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out waiting for %s", what);
        stop_with_failure();
    endtask

    // Model of the status byte; RTS is high exactly while a byte is pending.
    function automatic logic [7:0] expected_status(input logic byte_pending,
                                                   input logic tx_pending);
        logic [7:0] value;
        value    = 8'h00;
        value[0] = byte_pending;
        value[1] = tx_pending;
        value[2] = byte_pending;
        return value;
    endfunction

    // ------------------------------------------------------------
    // Wishbone master
    // ------------------------------------------------------------

    // Request held until ack, then dropped on the same falling edge.
    task automatic wb_access(input logic write_en, input logic [2:0] addr,
                             input logic [7:0] wdata, output logic [7:0] rdata);
        int waited;
        waited = 0;
        @(negedge clk);
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: write_en, adr: addr, dat: wdata};
        @(negedge clk);
        while (!wb_rsp.ack) begin
            if (waited == BUS_TIMEOUT) begin
                report_timeout("Wishbone ack");
            end
            waited = waited + 1;
            @(negedge clk);
        end
        rdata  = wb_rsp.dat;
        wb_req = '0;
    endtask

    task automatic wb_write(input logic [2:0] addr, input logic [7:0] wdata);
        logic [7:0] ignored;
        wb_access(1'b1, addr, wdata, ignored);
    endtask

    task automatic wb_read(input logic [2:0] addr, output logic [7:0] rdata);
        wb_access(1'b0, addr, 8'h00, rdata);
    endtask

    // Polls status until the masked bits reach the given level.
    task automatic wait_status_bit(input logic [7:0] mask, input logic level,
                                   output logic [7:0] status, input string what);
        int waited;
        waited = 0;
        wb_read(addr_status, status);
        while ((|(status & mask)) != level) begin
            if (waited == WAIT_TIMEOUT) begin
                report_timeout(what);
            end
            waited = waited + 1;
            wb_read(addr_status, status);
        end
    endtask

    // ------------------------------------------------------------
    // Serial line
    // ------------------------------------------------------------

    // Start bit, data LSB first, one stop bit; called on a falling edge.
    task automatic serial_send(input logic [7:0] data, input logic stop_level);
        logic [9:0] frame;
        frame = {stop_level, data, 1'b0};
        repeat (10) begin
            rxd_line = frame[0];
            frame    = frame >> 1;
            repeat (BIT_CYCLES) @(negedge clk);
        end
        rxd_line = 1'b1;
    endtask

    // Finds the start edge, then samples each bit at its middle.
    task automatic serial_capture(output logic [7:0] data, output logic stop_level);
        int waited;
        waited = 0;
        while (uart_txd) begin
            if (waited == WAIT_TIMEOUT) begin
                report_timeout("start bit on uart_txd");
            end
            waited = waited + 1;
            @(negedge clk);
        end
        repeat (BIT_CYCLES / 2) @(negedge clk);
        repeat (8) begin
            repeat (BIT_CYCLES) @(negedge clk);
            data = {uart_txd, data[7:1]};
        end
        repeat (BIT_CYCLES) @(negedge clk);
        stop_level = uart_txd;
    endtask

    // Byte pending, read it back, then the receiver frees up.
    task automatic receive_and_check(input logic [7:0] sent, input string what);
        logic [7:0] status;
        logic [7:0] got;
        wait_status_bit(VALID_MASK, 1'b1, status, "rx valid");
        check_eq(status, expected_status(1'b1, 1'b0), "status with byte pending");
        check_eq(8'(uart_rts), 8'h01, "rts pin with byte pending");
        wb_read(addr_rx_data, got);
        check_eq(got, sent, what);
        wait_status_bit(RTS_MASK, 1'b0, status, "rts release");
        check_eq(status, expected_status(1'b0, 1'b0), "status after rx read");
        check_eq(8'(uart_rts), 8'h00, "rts pin after rx read");
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------

    initial begin
        logic [7:0] sent;
        logic [7:0] second;
        logic [7:0] got;
        logic [7:0] status;
        logic       stop_level;
        int         rnd;
        seed     = 53111;
        wb_req   = '0;
        rxd_line = 1'b1;
        loopback = 1'b0;
        resetn   = 1'b0;
        repeat (8) @(negedge clk);

        // Pin levels forced by reset.
        check_eq(8'(uart_rts), 8'h01, "rts during reset");
        check_eq(8'(uart_txd), 8'h01, "txd during reset");
        check_eq(8'(wb_rsp.ack), 8'h00, "ack during reset");
        resetn = 1'b1;

        // Idle after reset.
        wb_read(addr_status, status);
        check_eq(status, expected_status(1'b0, 1'b0), "status after reset");
        check_eq(8'(uart_txd), 8'h01, "txd idle level");
        check_eq(8'(uart_rts), 8'h00, "rts after reset");
        wb_read(addr_tx_data, got);
        check_eq(got, 8'h00, "tx_data read");

        // Receive path.
        repeat (10) begin
            rnd  = $random(seed);
            sent = rnd[7:0];
            serial_send(sent, 1'b1);
            receive_and_check(sent, "rx_data byte");
        end

        // Bad stop bit. The receiver restarts on the low line, so the good frame follows at once.
        rnd  = $random(seed);
        serial_send(rnd[7:0], 1'b0);
        rnd  = $random(seed);
        sent = rnd[7:0];
        fork
            serial_send(sent, 1'b1);
            begin
                wb_read(addr_status, status);
                check_eq(status, expected_status(1'b0, 1'b0), "status after bad stop bit");
            end
        join
        receive_and_check(sent, "byte after bad frame");

        // Transmit path.
        repeat (10) begin
            rnd  = $random(seed);
            sent = rnd[7:0];
            wb_write(addr_tx_data, sent);
            fork
                serial_capture(got, stop_level);
                begin
                    wb_read(addr_status, status);
                    check_eq(status, expected_status(1'b0, 1'b1), "status during transmit");
                end
            join
            check_eq(got, sent, "byte on uart_txd");
            check_eq(8'(stop_level), 8'h01, "stop bit level");
            wait_status_bit(BUSY_MASK, 1'b0, status, "tx busy to clear");
        end

        // Write while busy is dropped.
        rnd    = $random(seed);
        sent   = rnd[7:0];
        rnd    = $random(seed);
        second = rnd[7:0];
        wb_write(addr_tx_data, sent);
        fork
            serial_capture(got, stop_level);
            begin
                wb_read(addr_status, status);
                check_eq(status, expected_status(1'b0, 1'b1), "busy before second write");
                wb_write(addr_tx_data, second);
            end
        join
        check_eq(got, sent, "first byte kept");
        wait_status_bit(BUSY_MASK, 1'b0, status, "tx busy to clear");
        check_eq(status, expected_status(1'b0, 1'b0), "status after dropped write");
        repeat (10 * BIT_CYCLES) begin
            @(negedge clk);
            check_eq(8'(uart_txd), 8'h01, "line idle after dropped write");
        end

        // Loopback.
        loopback = 1'b1;
        repeat (4) begin
            rnd  = $random(seed);
            sent = rnd[7:0];
            wb_write(addr_tx_data, sent);
            wait_status_bit(VALID_MASK, 1'b1, status, "loopback byte");
            wb_read(addr_rx_data, got);
            check_eq(got, sent, "loopback byte");
            wait_status_bit(BUSY_MASK, 1'b0, status, "tx busy to clear");
            wait_status_bit(RTS_MASK, 1'b0, status, "rts release");
            check_eq(status, expected_status(1'b0, 1'b0), "status after loopback");
        end

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/uart_props.sv
// Checks are disabled while resetn is low; the bind below attaches them to every uart_top.
`timescale 1ns/1ps
`default_nettype none

module uart_props (
    input logic                 clk,
    input logic                 resetn,
    input wb_pkg::wb_req_t      wb_req,
    input wb_pkg::wb_rsp_t      wb_rsp,
    input uart_pkg::rx_status_t rx_status
);

    // ------------------------------------------------------------
    // Wishbone handshake
    // ------------------------------------------------------------

    // Ack is a single-cycle pulse.
    ack_one_cycle: assert property (@(posedge clk) disable iff (!resetn)
        wb_rsp.ack |=> !wb_rsp.ack)
        else $error("ack held for more than one cycle");

    // Ack answers a request seen in the cycle before.
    ack_under_request: assert property (@(posedge clk) disable iff (!resetn)
        wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb))
        else $error("ack raised without cyc and stb");

    // A held byte keeps the sender off the line.
    valid_holds_rts: assert property (@(posedge clk) disable iff (!resetn)
        rx_status.valid |-> rx_status.rts)
        else $error("rx valid while rts is low");

endmodule

bind uart_top uart_props uart_props_i (
    .clk       (clk),
    .resetn    (resetn),
    .wb_req    (wb_req),
    .wb_rsp    (wb_rsp),
    .rx_status (rx_status)
);

`default_nettype wire

// File: rtl/uart_top.sv
// Bit rate fixed at build time; CLK_HZ must exceed BIT_RATE by enough for mid-bit sampling.
`timescale 1ns/1ps
`default_nettype none

module uart_top #(
    parameter int CLK_HZ    = 125_000_000,
    parameter int BIT_RATE  = 7_812_500,
    parameter int STOP_BITS = 1
) (
    input  logic            clk,
    input  logic            resetn,
    input  wb_pkg::wb_req_t wb_req,
    output wb_pkg::wb_rsp_t wb_rsp,
    input  logic            uart_rxd,
    output logic            uart_txd,
    output logic            uart_rts
);
    import uart_pkg::*;

    // Bit period minus one, in clock cycles.
    localparam int CYCLES_PER_BIT = (CLK_HZ - 1) / BIT_RATE;

    rx_status_t rx_status;
    logic       rx_read;
    logic       tx_busy;
    logic       tx_start;
    logic [7:0] tx_data;

    // Register block.
    uart_regs uart_regs_i (
        .clk       (clk),
        .resetn    (resetn),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .rx_status (rx_status),
        .rx_read   (rx_read),
        .tx_busy   (tx_busy),
        .tx_start  (tx_start),
        .tx_data   (tx_data)
    );

    // Receiver.
    uart_rx #(
        .CYCLES_PER_BIT (CYCLES_PER_BIT),
        .STOP_BITS      (STOP_BITS)
    ) uart_rx_i (
        .clk       (clk),
        .resetn    (resetn),
        .uart_rxd  (uart_rxd),
        .rx_read   (rx_read),
        .rx_status (rx_status)
    );

    // Transmitter.
    uart_tx #(
        .CYCLES_PER_BIT (CYCLES_PER_BIT),
        .STOP_BITS      (STOP_BITS)
    ) uart_tx_i (
        .clk      (clk),
        .resetn   (resetn),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .tx_busy  (tx_busy),
        .uart_txd (uart_txd)
    );

    assign uart_rts = rx_status.rts;

endmodule

`default_nettype wire

// File: rtl/uart_regs.sv
// One access at a time, ack one cycle after stb; writes to tx_data while busy are acked and dropped.
`timescale 1ns/1ps
`default_nettype none

module uart_regs (
    input  logic                 clk,
    input  logic                 resetn,
    input  wb_pkg::wb_req_t      wb_req,
    output wb_pkg::wb_rsp_t      wb_rsp,
    input  uart_pkg::rx_status_t rx_status,
    output logic                 rx_read,
    input  logic                 tx_busy,
    output logic                 tx_start,
    output logic [7:0]           tx_data
);
    import wb_pkg::*;

    logic              access;
    logic              rd_access;
    logic              wr_access;
    reg_addr_t         addr;
    logic [DATA_W-1:0] status_byte;
    logic              ack_q;
    logic [DATA_W-1:0] rd_q;
    logic              rx_read_q;
    logic              tx_start_q;
    logic [DATA_W-1:0] tx_data_q;

    // ------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------

    // A new access starts only while ack is low.
    assign access    = wb_req.cyc && wb_req.stb && !ack_q;
    assign rd_access = access && !wb_req.we;
    assign wr_access = access && wb_req.we;
    assign addr      = reg_addr_t'(wb_req.adr);

    // Status byte layout.
    always_comb begin
        status_byte                = '0;
        status_byte[STAT_RX_VALID] = rx_status.valid;
        status_byte[STAT_TX_BUSY]  = tx_busy;
        status_byte[STAT_RTS]      = rx_status.rts;
    end

    // ------------------------------------------------------------
    // Handshake and side-effect pulses
    // ------------------------------------------------------------

    // Pulses land in the ack cycle.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            ack_q      <= 1'b0;
            rx_read_q  <= 1'b0;
            tx_start_q <= 1'b0;
        end else begin
            ack_q <= access;
            // Release only a byte that is really held.
            rx_read_q  <= rd_access && addr == addr_rx_data && rx_status.valid;
            // Drop the write if a frame is still going out.
            tx_start_q <= wr_access && addr == addr_tx_data && !tx_busy;
        end
    end

    // Read data, valid with ack.
    always_ff @(posedge clk) begin
        if (rd_access) begin
            case (addr)
                addr_rx_data: rd_q <= rx_status.data;
                addr_status:  rd_q <= status_byte;
                default:      rd_q <= '0;
            endcase
        end
    end

    // Transmit byte, held for the transmitter latch.
    always_ff @(posedge clk) begin
        if (wr_access && addr == addr_tx_data) begin
            tx_data_q <= wb_req.dat;
        end
    end

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = rd_q;
    assign rx_read    = rx_read_q;
    assign tx_start   = tx_start_q;
    assign tx_data    = tx_data_q;

endmodule

`default_nettype wire

// File: rtl/uart_tx.sv
// Sends start, 8 data bits LSB first and STOP_BITS stop bits; tx_start must not pulse while busy.
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
    parameter int CYCLES_PER_BIT = 15,
    parameter int STOP_BITS      = 1
) (
    input  logic       clk,
    input  logic       resetn,
    input  logic       tx_start,
    input  logic [7:0] tx_data,
    output logic       tx_busy,
    output logic       uart_txd
);
    import uart_pkg::*;

    localparam int COUNT_W  = $clog2(CYCLES_PER_BIT + 1);
    localparam int MAX_BITS = (DATA_BITS > STOP_BITS) ? DATA_BITS : STOP_BITS;
    localparam int BIT_W    = $clog2(MAX_BITS + 1);

    tx_state_t            state;
    logic [COUNT_W-1:0]   cycle_count;
    logic [BIT_W-1:0]     bit_count;
    logic [DATA_BITS-1:0] shift_q;
    logic                 txd_q;
    logic                 next_bit;

    // Each bit lasts CYCLES_PER_BIT + 1 cycles.
    assign next_bit = cycle_count == COUNT_W'(CYCLES_PER_BIT);

    // Byte latch and shifter.
    // The register block only starts an idle transmitter.
    always_ff @(posedge clk) begin
        if (tx_start) begin
            shift_q <= tx_data;
        end else if (state == tx_st_data && next_bit) begin
            shift_q <= shift_q >> 1;
        end
    end

    // ------------------------------------------------------------
    // FSM and line driver
    // ------------------------------------------------------------

    // txd changes on the same edge as the state, so each bit lines up with its state.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state       <= tx_st_idle;
            cycle_count <= '0;
            bit_count   <= '0;
            txd_q       <= 1'b1;
        end else begin
            if (state == tx_st_idle || next_bit) begin
                cycle_count <= '0;
            end else begin
                cycle_count <= cycle_count + 1'b1;
            end
            case (state)
                tx_st_idle: begin
                    bit_count <= '0;
                    if (tx_start) begin
                        state <= tx_st_start;
                        txd_q <= 1'b0;
                    end else begin
                        txd_q <= 1'b1;
                    end
                end
                tx_st_start: begin
                    if (next_bit) begin
                        state <= tx_st_data;
                        txd_q <= shift_q[0];
                    end
                end
                tx_st_data: begin
                    if (next_bit) begin
                        if (bit_count == BIT_W'(DATA_BITS - 1)) begin
                            // Last data bit done.
                            state     <= tx_st_stop;
                            bit_count <= '0;
                            txd_q     <= 1'b1;
                        end else begin
                            bit_count <= bit_count + 1'b1;
                            txd_q     <= shift_q[1];
                        end
                    end
                end
                tx_st_stop: begin
                    // Line stays high for every stop bit.
                    if (next_bit) begin
                        if (bit_count == BIT_W'(STOP_BITS - 1)) begin
                            state <= tx_st_idle;
                        end else begin
                            bit_count <= bit_count + 1'b1;
                        end
                    end
                end
                default: state <= tx_st_idle;
            endcase
        end
    end

    assign tx_busy  = state != tx_st_idle;
    assign uart_txd = txd_q;

endmodule

`default_nettype wire

// File: rtl/uart_rx.sv
// Samples once per bit at mid-count with no majority vote; bad stop bit drops the frame silently.
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
    parameter int CYCLES_PER_BIT = 15,
    parameter int STOP_BITS      = 1
) (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 uart_rxd,
    input  logic                 rx_read,
    output uart_pkg::rx_status_t rx_status
);
    import uart_pkg::*;

    // Counter widths.
    localparam int COUNT_W  = $clog2(CYCLES_PER_BIT + 1);
    localparam int MAX_BITS = (DATA_BITS > STOP_BITS) ? DATA_BITS : STOP_BITS;
    localparam int BIT_W    = $clog2(MAX_BITS + 1);

    logic                 rxd_meta;
    logic                 rxd_sync;
    rx_state_t            state;
    rx_state_t            state_next;
    logic [COUNT_W-1:0]   cycle_count;
    logic [BIT_W-1:0]     bit_count;
    logic [DATA_BITS-1:0] shift_q;
    logic                 rts_q;
    logic                 next_bit;
    logic                 mid_bit;
    logic                 last_data;
    logic                 last_stop;

    // ------------------------------------------------------------
    // Input synchronizer
    // ------------------------------------------------------------

    // Two flops, idle line is high.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= uart_rxd;
            rxd_sync <= rxd_meta;
        end
    end

    // Bit timing strobes.
    assign next_bit  = cycle_count == COUNT_W'(CYCLES_PER_BIT);
    assign mid_bit   = cycle_count == COUNT_W'(CYCLES_PER_BIT / 2);
    assign last_data = bit_count == BIT_W'(DATA_BITS - 1);
    assign last_stop = bit_count == BIT_W'(STOP_BITS - 1);

    // ------------------------------------------------------------
    // FSM
    // ------------------------------------------------------------

    always_comb begin
        state_next = state;
        case (state)
            rx_st_idle: begin
                // Falling edge marks the start bit.
                if (!rxd_sync) begin
                    state_next = rx_st_start;
                end
            end
            rx_st_start: begin
                if (next_bit) begin
                    state_next = rx_st_data;
                end
            end
            rx_st_data: begin
                if (next_bit && last_data) begin
                    state_next = rx_st_stop;
                end
            end
            rx_st_stop: begin
                // A low stop bit discards the frame.
                if (mid_bit) begin
                    if (!rxd_sync) begin
                        state_next = rx_st_idle;
                    end else if (last_stop) begin
                        state_next = rx_st_ready;
                    end
                end
            end
            rx_st_ready: begin
                if (rx_read) begin
                    state_next = rx_st_idle;
                end
            end
            default: state_next = rx_st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= rx_st_idle;
        end else begin
            state <= state_next;
        end
    end

    // Cycle counter restarts at every bit boundary.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            cycle_count <= '0;
        end else if (state == rx_st_idle || state == rx_st_ready || next_bit) begin
            cycle_count <= '0;
        end else begin
            cycle_count <= cycle_count + 1'b1;
        end
    end

    // Counts data bits, then stop bits.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            bit_count <= '0;
        end else if (state == rx_st_data || state == rx_st_stop) begin
            if (next_bit) begin
                if (state == rx_st_data && last_data) begin
                    bit_count <= '0;
                end else begin
                    bit_count <= bit_count + 1'b1;
                end
            end
        end else begin
            bit_count <= '0;
        end
    end

    // LSB arrives first, so shift in from the top.
    always_ff @(posedge clk) begin
        if (state == rx_st_data && mid_bit) begin
            shift_q <= {rxd_sync, shift_q[DATA_BITS-1:1]};
        end
    end

    // Not ready from the data state until the byte is read.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            rts_q <= 1'b1;
        end else begin
            rts_q <= !(state == rx_st_idle || state == rx_st_start);
        end
    end

    assign rx_status.valid = state == rx_st_ready;
    assign rx_status.rts   = rts_q;
    assign rx_status.data  = shift_q;

endmodule

`default_nettype wire

// File: rtl/wb_pkg.sv
// Wishbone classic types for an 8-bit slave with a 3-bit byte address; no select lines or errors.
`default_nettype none

package wb_pkg;

    // Bus widths.
    localparam int ADDR_W = 3;
    localparam int DATA_W = 8;

    // Master to slave.
    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [ADDR_W-1:0] adr;
        logic [DATA_W-1:0] dat;
    } wb_req_t;

    // Slave to master.
    typedef struct packed {
        logic              ack;
        logic [DATA_W-1:0] dat;
    } wb_rsp_t;

    // Register map.
    typedef enum logic [ADDR_W-1:0] {
        addr_rx_data = 3'd0,
        addr_tx_data = 3'd1,
        addr_status  = 3'd2
    } reg_addr_t;

    // Status register bit positions.
    localparam int STAT_RX_VALID = 0;
    localparam int STAT_TX_BUSY  = 1;
    localparam int STAT_RTS      = 2;

endpackage

`default_nettype wire

// File: rtl/uart_pkg.sv
// Serial line types only; payload is fixed at 8 data bits, no parity and no flow-control input.
`default_nettype none

package uart_pkg;

    // ------------------------------------------------------------
    // Frame format
    // ------------------------------------------------------------

    // Data bits per frame, LSB first on the line.
    localparam int DATA_BITS = 8;

    // ------------------------------------------------------------
    // FSM encodings
    // ------------------------------------------------------------

    // Receiver FSM.
    // The ready state holds a byte and ignores the line.
    typedef enum logic [2:0] {
        rx_st_idle  = 3'd0,
        rx_st_start = 3'd1,
        rx_st_data  = 3'd2,
        rx_st_stop  = 3'd3,
        rx_st_ready = 3'd4
    } rx_state_t;

    // Transmitter FSM.
    typedef enum logic [1:0] {
        tx_st_idle  = 2'd0,
        tx_st_start = 2'd1,
        tx_st_data  = 2'd2,
        tx_st_stop  = 2'd3
    } tx_state_t;

    // Receiver view as seen by the register block.
    // rts is active low, high means no new frame can be taken.
    typedef struct packed {
        logic                 valid;
        logic                 rts;
        logic [DATA_BITS-1:0] data;
    } rx_status_t;

endpackage

`default_nettype wire
